// ==== hw/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // instruction field positions used by the jump decode.
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int FUNCT_HI  = 5;
    localparam int FUNCT_LO  = 0;

    // major opcodes, only the ones the front end cares about.
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        REGIMM  = 6'h01,  // bltz, bgez and the linking forms.
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLEZ    = 6'h06,
        BGTZ    = 6'h07
    } opcode_e;

    // register jumps under SPECIAL.
    typedef enum logic [5:0] {
        JR   = 6'h08,
        JALR = 6'h09
    } funct_e;

endpackage

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // delay-slot redirect sequence.
    typedef enum logic [1:0] {
        NORMAL       = 2'd0,
        FETCH_DS     = 2'd1,  // delay slot fetched, target pending.
        FETCH_TARGET = 2'd2   // target fetched, drop slot 2.
    } fetch_state_e;

    // boot rom entry.
    localparam logic [31:0] RESET_PC = 32'hbfc00000;

    // bht indexed by pc[9:2].
    localparam int BHT_IDX_W = 8;
    localparam int BHT_DEPTH = 1 << BHT_IDX_W;

    // btb indexed by pc[7:2], tagged with the rest.
    localparam int BTB_IDX_W   = 6;
    localparam int BTB_DEPTH   = 1 << BTB_IDX_W;
    localparam int BTB_TAG_LSB = BTB_IDX_W + 2;
    localparam int BTB_TAG_W   = 32 - BTB_TAG_LSB;

endpackage

// ==== hw/pc_gen.sv ====
`timescale 1ns/100ps

module pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        fifo_stall,
    input  logic        i_cache_stall,
    input  logic        fetch_ena,
    input  logic [31:0] fetch_target,
    output logic [31:0] pc,
    output logic        pc_valid
);
    import fetch_pkg::*;

    logic step;

    // a pair only moves on when both the fifo and the icache can take it.
    assign step = !fifo_stall && !i_cache_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            if (fetch_ena) begin
                pc <= fetch_target;  // redirect wins over stepping.
            end else if (step) begin
                pc <= pc + 32'd8;
            end
        end
    end

    // first cycle out of reset has nothing fetched yet.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
        end
    end

    // without a redirect pc moves by whole pairs, so the
    // position inside the pair never changes.
    a_pair_step: assert property (@(posedge clk) disable iff (rst)
        !fetch_ena |=> pc[2:0] == $past(pc[2:0]))
        else $error("pc left its pair alignment without a redirect");

endmodule

// ==== hw/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
    input  logic        clk,
    input  logic        rst,
    input  logic        ex_stall,
    input  logic [31:0] pc,
    input  logic [31:0] ex_pc,
    input  logic        ex_is_jmp,
    input  logic        ex_act_taken,
    input  logic [31:0] ex_act_target,
    output logic        pred_taken_1,
    output logic        pred_taken_2,
    output logic [31:0] pred_target_1,
    output logic [31:0] pred_target_2
);
    import fetch_pkg::*;

    // 2-bit saturating counters.
    logic [1:0]           bht        [BHT_DEPTH];

    logic                 btb_valid  [BTB_DEPTH];
    logic [BTB_TAG_W-1:0] btb_tag    [BTB_DEPTH];
    logic [31:0]          btb_target [BTB_DEPTH];

    // read ports, one per slot of the pair.
    logic [31:0]          rd_addr    [2];
    logic                 rd_taken   [2];
    logic [31:0]          rd_target  [2];

    // update port.
    logic                 upd;
    logic [BHT_IDX_W-1:0] ex_bht_idx;
    logic [BTB_IDX_W-1:0] ex_btb_idx;
    logic [1:0]           ex_cnt;
    logic [1:0]           ex_cnt_next;

    assign rd_addr[0] = pc;
    assign rd_addr[1] = pc + 32'd4;

    for (genvar p = 0; p < 2; p++) begin : g_rd
        logic [BHT_IDX_W-1:0] bht_idx;
        logic [BTB_IDX_W-1:0] btb_idx;
        logic                 hit;

        assign bht_idx = rd_addr[p][BHT_IDX_W+1:2];
        assign btb_idx = rd_addr[p][BTB_IDX_W+1:2];
        assign hit     = btb_valid[btb_idx]
                         && (btb_tag[btb_idx] == rd_addr[p][31:BTB_TAG_LSB]);

        // strongly or weakly taken, and we know where to.
        assign rd_taken[p]  = bht[bht_idx][1] && hit;
        // on a miss fall through past the delay slot.
        assign rd_target[p] = hit ? btb_target[btb_idx] : rd_addr[p] + 32'd8;
    end

    assign pred_taken_1  = rd_taken[0];
    assign pred_taken_2  = rd_taken[1];
    assign pred_target_1 = rd_target[0];
    assign pred_target_2 = rd_target[1];

    assign upd        = ex_is_jmp && !ex_stall;
    assign ex_bht_idx = ex_pc[BHT_IDX_W+1:2];
    assign ex_btb_idx = ex_pc[BTB_IDX_W+1:2];
    assign ex_cnt     = bht[ex_bht_idx];

    always_comb begin
        if (ex_act_taken) begin
            ex_cnt_next = (ex_cnt == 2'b11) ? 2'b11 : ex_cnt + 2'd1;
        end else begin
            ex_cnt_next = (ex_cnt == 2'b00) ? 2'b00 : ex_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_DEPTH; i++) begin
                bht[i] <= 2'b01;  // weakly not taken.
            end
            for (int i = 0; i < BTB_DEPTH; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (upd) begin
            bht[ex_bht_idx] <= ex_cnt_next;
            if (ex_act_taken) begin
                btb_valid[ex_btb_idx] <= 1'b1;
            end
        end
    end

    // btb payload, only taken branches allocate.
    always_ff @(posedge clk) begin
        if (upd && ex_act_taken) begin
            btb_tag[ex_btb_idx]    <= ex_pc[31:BTB_TAG_LSB];
            btb_target[ex_btb_idx] <= ex_act_target;
        end
    end

    // a stalled execute report must leave its counter untouched.
    a_no_upd_on_stall: assert property (@(posedge clk) disable iff (rst)
        ex_stall ##1 (ex_pc == $past(ex_pc)) |-> ex_cnt == $past(ex_cnt))
        else $error("bht entry changed under ex_stall");

endmodule

// ==== hw/dynamic_fetch.sv ====
`timescale 1ns/100ps

module dynamic_fetch (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        flush,
    input  logic        ex_stall,
    input  logic [31:0] ex_pc,
    input  logic        ex_is_jmp,
    input  logic        ex_act_taken,
    input  logic [31:0] ex_act_target,
    input  logic        flush_req,
    input  logic        fifo_stall,
    input  logic        i_cache_stall,
    input  logic        pc_valid,
    input  logic [31:0] pc,
    input  logic [31:0] inst_1,
    input  logic [31:0] inst_2,
    input  logic        inst_ok_1,
    input  logic        inst_ok_2,
    input  logic        raw_taken_1,
    input  logic        raw_taken_2,
    input  logic [31:0] raw_target_1,
    input  logic [31:0] raw_target_2,
    output logic        flush_pc_reg,
    output logic        fetch_ena,
    output logic [31:0] fetch_target,
    output logic        pred_taken_1,
    output logic        pred_taken_2,
    output logic [31:0] pred_target_1,
    output logic [31:0] pred_target_2,
    output logic        w_fifo_en_1,
    output logic        w_fifo_en_2,
    output logic [31:0] jmp_total,
    output logic [31:0] jmp_flush
);
    import mips_isa_pkg::*;
    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic [31:0]  ds_target;    // target waiting behind the delay slot.
    logic [31:0]  saved_target;
    logic [31:0]  flush_target;
    logic         only_ds;
    logic         fifo_ok;

    // branches and jumps, including jr/jalr.
    function automatic logic is_jump(input logic [31:0] inst);
        opcode_e opc;
        funct_e  fn;
        opc = opcode_e'(inst[OPCODE_HI:OPCODE_LO]);
        fn  = funct_e'(inst[FUNCT_HI:FUNCT_LO]);
        case (opc)
            REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ: is_jump = 1'b1;
            SPECIAL: is_jump = (fn == JR) || (fn == JALR);
            default: is_jump = 1'b0;
        endcase
    endfunction

    // the predictor only sees addresses, so gate by the decode.
    assign pred_taken_1  = raw_taken_1 && is_jump(inst_1) && inst_ok_1;
    assign pred_taken_2  = raw_taken_2 && is_jump(inst_2) && inst_ok_2;
    assign pred_target_1 = raw_target_1;
    assign pred_target_2 = raw_target_2;

    assign fifo_ok     = !fifo_stall && !i_cache_stall && pc_valid;
    assign w_fifo_en_1 = inst_ok_1 && fifo_ok;
    assign w_fifo_en_2 = inst_ok_2 && fifo_ok && !only_ds;

    assign flush_target = ex_act_taken ? ex_act_target : ex_pc + 32'd8;

    always_comb begin
        state_d      = NORMAL;
        fetch_ena    = 1'b0;
        fetch_target = 32'h0;
        flush_pc_reg = 1'b0;
        ds_target    = 32'h0;
        only_ds      = 1'b0;
        if (flush_req) begin
            // execute knows better, in any state.
            fetch_ena    = 1'b1;
            fetch_target = flush_target;
            flush_pc_reg = 1'b1;
        end else begin
            case (state_q)
                NORMAL: begin
                    if (pred_taken_1 && inst_ok_2) begin
                        // delay slot already in hand.
                        fetch_ena    = 1'b1;
                        fetch_target = raw_target_1;
                        flush_pc_reg = 1'b1;
                    end else if (pred_taken_1) begin
                        state_d      = FETCH_DS;
                        fetch_ena    = 1'b1;
                        fetch_target = pc + 32'd4;
                        flush_pc_reg = 1'b1;
                        ds_target    = raw_target_1;
                    end else if (pred_taken_2) begin
                        state_d      = FETCH_DS;
                        fetch_ena    = 1'b1;
                        fetch_target = pc + 32'd8;
                        flush_pc_reg = 1'b1;
                        ds_target    = raw_target_2;
                    end
                end
                FETCH_DS: begin
                    state_d      = FETCH_TARGET;
                    fetch_ena    = 1'b1;
                    fetch_target = saved_target;
                end
                FETCH_TARGET: begin
                    only_ds = 1'b1;  // word after the slot is not on the path.
                end
                default: begin
                    state_d = NORMAL;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q <= NORMAL;
        end else if (!stall) begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && state_d == FETCH_DS) begin
            saved_target <= ds_target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            jmp_total <= 32'h0;
            jmp_flush <= 32'h0;
        end else if (!ex_stall) begin
            if (ex_is_jmp) begin
                jmp_total <= jmp_total + 32'd1;
            end
            if (flush_req) begin
                jmp_flush <= jmp_flush + 32'd1;
            end
        end
    end

    a_flush_has_ena: assert property (@(posedge clk) disable iff (rst)
        flush_pc_reg |-> fetch_ena)
        else $error("flush_pc_reg without fetch_ena");

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state_q inside {NORMAL, FETCH_DS, FETCH_TARGET})
        else $error("fetch state took the unused encoding");

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        flush,
    input  logic        fifo_stall,
    input  logic        i_cache_stall,
    input  logic [31:0] inst_1,
    input  logic        inst_ok_1,
    input  logic [31:0] inst_2,
    input  logic        inst_ok_2,
    input  logic        ex_stall,
    input  logic [31:0] ex_pc,
    input  logic        ex_is_jmp,
    input  logic        ex_act_taken,
    input  logic [31:0] ex_act_target,
    input  logic        flush_req,
    output logic [31:0] pc,
    output logic        pc_valid,
    output logic        flush_pc_reg,
    output logic        fetch_ena,
    output logic [31:0] fetch_target,
    output logic        pred_taken_1,
    output logic [31:0] pred_target_1,
    output logic        pred_taken_2,
    output logic [31:0] pred_target_2,
    output logic        w_fifo_en_1,
    output logic        w_fifo_en_2,
    output logic [31:0] jmp_total,
    output logic [31:0] jmp_flush
);
    // predictor output before the jump decode.
    logic        raw_taken_1;
    logic        raw_taken_2;
    logic [31:0] raw_target_1;
    logic [31:0] raw_target_2;

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .fifo_stall    (fifo_stall),
        .i_cache_stall (i_cache_stall),
        .fetch_ena     (fetch_ena),
        .fetch_target  (fetch_target),
        .pc            (pc),
        .pc_valid      (pc_valid)
    );

    branch_predictor u_predictor (
        .clk           (clk),
        .rst           (rst),
        .ex_stall      (ex_stall),
        .pc            (pc),
        .ex_pc         (ex_pc),
        .ex_is_jmp     (ex_is_jmp),
        .ex_act_taken  (ex_act_taken),
        .ex_act_target (ex_act_target),
        .pred_taken_1  (raw_taken_1),
        .pred_taken_2  (raw_taken_2),
        .pred_target_1 (raw_target_1),
        .pred_target_2 (raw_target_2)
    );

    dynamic_fetch u_dynamic_fetch (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .ex_stall      (ex_stall),
        .ex_pc         (ex_pc),
        .ex_is_jmp     (ex_is_jmp),
        .ex_act_taken  (ex_act_taken),
        .ex_act_target (ex_act_target),
        .flush_req     (flush_req),
        .fifo_stall    (fifo_stall),
        .i_cache_stall (i_cache_stall),
        .pc_valid      (pc_valid),
        .pc            (pc),
        .inst_1        (inst_1),
        .inst_2        (inst_2),
        .inst_ok_1     (inst_ok_1),
        .inst_ok_2     (inst_ok_2),
        .raw_taken_1   (raw_taken_1),
        .raw_taken_2   (raw_taken_2),
        .raw_target_1  (raw_target_1),
        .raw_target_2  (raw_target_2),
        .flush_pc_reg  (flush_pc_reg),
        .fetch_ena     (fetch_ena),
        .fetch_target  (fetch_target),
        .pred_taken_1  (pred_taken_1),
        .pred_taken_2  (pred_taken_2),
        .pred_target_1 (pred_target_1),
        .pred_target_2 (pred_target_2),
        .w_fifo_en_1   (w_fifo_en_1),
        .w_fifo_en_2   (w_fifo_en_2),
        .jmp_total     (jmp_total),
        .jmp_flush     (jmp_flush)
    );

endmodule

// ==== tests/tb_fetch_unit.sv ====
`timescale 1ns/100ps

module tb_fetch_unit;
    import mips_isa_pkg::*;
    import fetch_pkg::*;

    localparam logic [31:0] ADDR_A  = RESET_PC + 32'h100;  // beq, slot 1.
    localparam logic [31:0] ADDR_N  = RESET_PC + 32'h208;  // nop that gets a btb entry.
    localparam logic [31:0] ADDR_B  = RESET_PC + 32'h300;  // bne sits at B+4.
    localparam logic [31:0] ADDR_JR = RESET_PC + 32'h600;
    localparam logic [31:0] TGT_A   = RESET_PC + 32'h400;
    localparam logic [31:0] TGT_B   = RESET_PC + 32'h500;
    localparam int          MAX_CYCLES = 2000;

    logic clk, rst, stall, flush, fifo_stall, i_cache_stall;
    logic [31:0] inst_1, inst_2;
    logic inst_ok_1, inst_ok_2;
    logic ex_stall, ex_is_jmp, ex_act_taken, flush_req;
    logic [31:0] ex_pc, ex_act_target;
    logic [31:0] pc, fetch_target, pred_target_1, pred_target_2, jmp_total, jmp_flush;
    logic pc_valid, flush_pc_reg, fetch_ena, pred_taken_1, pred_taken_2;
    logic w_fifo_en_1, w_fifo_en_2;

    // shadow of the front end, built from the fetch rules.
    logic [1:0]  sh_bht [256];
    logic        sh_btb_v [64];
    logic [23:0] sh_btb_tag [64];
    logic [31:0] sh_btb_tgt [64];
    logic [31:0] sh_pc, sh_saved, sh_total, sh_flush;
    logic        sh_valid, sh_pt1, sh_pt2, ok_path, keep_2;
    fetch_state_e sh_state, exp_next;
    logic        exp_ena, exp_fpr, exp_wen1, exp_wen2;
    logic [31:0] exp_target, exp_ds;

    logic [31:0] lfsr;
    logic [31:0] rnd;
    int          errors;
    int          cycles;

    fetch_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction memory, nop everywhere but the branch table.
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        case (addr)
            ADDR_A:         inst_at = {BEQ, 5'd1, 5'd2, 16'h00ff};
            ADDR_N:         inst_at = 32'h0;
            ADDR_B + 32'd4: inst_at = {BNE, 5'd3, 5'd4, 16'h0080};
            ADDR_JR:        inst_at = {SPECIAL, 5'd31, 15'd0, JR};
            default:        inst_at = 32'h0;
        endcase
    endfunction

    function automatic logic decodes_jump(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == SPECIAL) begin
            decodes_jump = (w[5:0] == JR) || (w[5:0] == JALR);
        end else begin
            decodes_jump = op inside {REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ};
        end
    endfunction

    function automatic logic btb_hit(input logic [31:0] a);
        btb_hit = sh_btb_v[a[7:2]] && (sh_btb_tag[a[7:2]] == a[31:8]);
    endfunction

    function automatic logic bp_taken(input logic [31:0] a);
        bp_taken = (sh_bht[a[9:2]] >= 2'd2) && btb_hit(a);
    endfunction

    function automatic logic [31:0] bp_target(input logic [31:0] a);
        bp_target = btb_hit(a) ? sh_btb_tgt[a[7:2]] : a + 32'd8;
    endfunction

    assign inst_1 = inst_at(pc);
    assign inst_2 = inst_at(pc + 32'd4);

    always_comb begin
        ok_path    = !fifo_stall && !i_cache_stall && sh_valid;
        sh_pt1     = bp_taken(sh_pc) && decodes_jump(inst_at(sh_pc)) && inst_ok_1;
        sh_pt2     = bp_taken(sh_pc + 32'd4) && decodes_jump(inst_at(sh_pc + 32'd4))
                     && inst_ok_2;
        exp_ena    = 1'b0;
        exp_fpr    = 1'b0;
        exp_target = 32'h0;
        exp_next   = NORMAL;
        exp_ds     = 32'h0;
        keep_2     = 1'b1;
        if (flush_req) begin
            exp_ena    = 1'b1;
            exp_fpr    = 1'b1;
            exp_target = ex_act_taken ? ex_act_target : ex_pc + 32'd8;
        end else if (sh_state == NORMAL) begin
            if (sh_pt1 && inst_ok_2) begin
                exp_ena    = 1'b1;
                exp_fpr    = 1'b1;
                exp_target = bp_target(sh_pc);
            end else if (sh_pt1 || sh_pt2) begin
                exp_ena    = 1'b1;
                exp_fpr    = 1'b1;
                exp_next   = FETCH_DS;
                exp_target = sh_pt1 ? sh_pc + 32'd4 : sh_pc + 32'd8;
                exp_ds     = sh_pt1 ? bp_target(sh_pc) : bp_target(sh_pc + 32'd4);
            end
        end else if (sh_state == FETCH_DS) begin
            exp_ena    = 1'b1;
            exp_target = sh_saved;
            exp_next   = FETCH_TARGET;
        end else begin
            keep_2 = 1'b0;  // only the delay slot survives.
        end
        exp_wen1 = inst_ok_1 && ok_path;
        exp_wen2 = inst_ok_2 && ok_path && keep_2;
    end

    always @(posedge clk) begin
        if (rst) begin
            sh_pc    <= RESET_PC;
            sh_valid <= 1'b0;
            sh_total <= 32'h0;
            sh_flush <= 32'h0;
            for (int i = 0; i < 256; i++) sh_bht[i] <= 2'd1;
            for (int i = 0; i < 64; i++) sh_btb_v[i] <= 1'b0;
        end else begin
            sh_valid <= 1'b1;
            if (!stall) begin
                if (exp_ena) sh_pc <= exp_target;
                else if (!fifo_stall && !i_cache_stall) sh_pc <= sh_pc + 32'd8;
                if (exp_next == FETCH_DS) sh_saved <= exp_ds;
            end
            if (!ex_stall) begin
                if (ex_is_jmp) begin
                    sh_total <= sh_total + 32'd1;
                    if (ex_act_taken && sh_bht[ex_pc[9:2]] != 2'd3)
                        sh_bht[ex_pc[9:2]] <= sh_bht[ex_pc[9:2]] + 2'd1;
                    if (!ex_act_taken && sh_bht[ex_pc[9:2]] != 2'd0)
                        sh_bht[ex_pc[9:2]] <= sh_bht[ex_pc[9:2]] - 2'd1;
                    if (ex_act_taken) begin
                        sh_btb_v[ex_pc[7:2]]   <= 1'b1;
                        sh_btb_tag[ex_pc[7:2]] <= ex_pc[31:8];
                        sh_btb_tgt[ex_pc[7:2]] <= ex_act_target;
                    end
                end
                if (flush_req) sh_flush <= sh_flush + 32'd1;
            end
        end
        if (rst || flush) sh_state <= NORMAL;
        else if (!stall) sh_state <= exp_next;
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    chk_reset: assert property (@(posedge clk) $fell(rst) |-> pc == RESET_PC
        && jmp_total == 0 && jmp_flush == 0 && !fetch_ena && !flush_pc_reg)
        else report_fail("state after reset");
    chk_pc: assert property (@(posedge clk) disable iff (rst) pc == sh_pc)
        else report_fail("pc mismatch");
    chk_valid: assert property (@(posedge clk) disable iff (rst) pc_valid == sh_valid)
        else report_fail("pc_valid mismatch");
    chk_pred: assert property (@(posedge clk) disable iff (rst)
        pred_taken_1 == sh_pt1 && pred_taken_2 == sh_pt2)
        else report_fail("qualified prediction mismatch");
    chk_ptarget: assert property (@(posedge clk) disable iff (rst)
        pred_target_1 == bp_target(sh_pc) && pred_target_2 == bp_target(sh_pc + 32'd4))
        else report_fail("prediction target mismatch");
    chk_ena: assert property (@(posedge clk) disable iff (rst)
        fetch_ena == exp_ena && flush_pc_reg == exp_fpr)
        else report_fail("fetch_ena or flush_pc_reg mismatch");
    chk_target: assert property (@(posedge clk) disable iff (rst)
        exp_ena |-> fetch_target == exp_target)
        else report_fail("fetch_target mismatch");
    chk_wen: assert property (@(posedge clk) disable iff (rst)
        w_fifo_en_1 == exp_wen1 && w_fifo_en_2 == exp_wen2)
        else report_fail("fifo write enable mismatch");
    chk_count: assert property (@(posedge clk) disable iff (rst)
        jmp_total == sh_total && jmp_flush == sh_flush)
        else report_fail("jump counter mismatch");

    // fibonacci lfsr, taps 32 22 2 1, one step per bit.
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        draw_bits = v;
    endfunction

    task automatic idle_gap();
        rnd = draw_bits(2);
        repeat (rnd) @(posedge clk);
    endtask

    task automatic train(input logic [31:0] addr, input logic [31:0] tgt);
        ex_pc         <= addr;
        ex_is_jmp     <= 1'b1;
        ex_act_taken  <= 1'b1;
        ex_act_target <= tgt;
        @(posedge clk);
        ex_is_jmp     <= 1'b0;
        ex_act_taken  <= 1'b0;
    endtask

    task automatic mispredict(input logic [31:0] epc, input logic taken,
                              input logic [31:0] tgt, input logic hold);
        ex_pc         <= epc;
        ex_is_jmp     <= 1'b1;
        ex_act_taken  <= taken;
        ex_act_target <= tgt;
        ex_stall      <= hold;
        flush_req     <= 1'b1;
        @(posedge clk);
        ex_is_jmp     <= 1'b0;
        ex_act_taken  <= 1'b0;
        ex_stall      <= 1'b0;
        flush_req     <= 1'b0;
    endtask

    // flush with no jump report, just to move fetch somewhere.
    task automatic redirect(input logic [31:0] tgt);
        ex_act_taken  <= 1'b1;
        ex_act_target <= tgt;
        flush_req     <= 1'b1;
        @(posedge clk);
        ex_act_taken  <= 1'b0;
        flush_req     <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        lfsr = 32'h1effc6cf;
        errors = 0;
        cycles = 0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        fifo_stall = 1'b0;
        i_cache_stall = 1'b0;
        inst_ok_1 = 1'b1;
        inst_ok_2 = 1'b1;
        ex_stall = 1'b0;
        ex_pc = 32'h0;
        ex_is_jmp = 1'b0;
        ex_act_taken = 1'b0;
        ex_act_target = 32'h0;
        flush_req = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // sequential fetch with random back-pressure.
        repeat (24) begin
            @(posedge clk);
            rnd = draw_bits(3);
            fifo_stall    <= (rnd == 0);
            i_cache_stall <= (rnd == 1);
            stall         <= (rnd == 2);
        end
        fifo_stall <= 1'b0;
        i_cache_stall <= 1'b0;
        stall <= 1'b0;
        repeat (4) @(posedge clk);
        // training and slot-1 redirect; the nop must stay unpredicted.
        train(ADDR_A, TGT_A);
        train(ADDR_A, TGT_A);
        train(ADDR_N, TGT_A + 32'h40);
        train(ADDR_N, TGT_A + 32'h40);
        redirect(ADDR_A);
        repeat (3) @(posedge clk);
        redirect(ADDR_N);
        repeat (3) @(posedge clk);
        idle_gap();
        // delay-slot sequence, slot 2 then slot 1 alone.
        train(ADDR_B + 32'd4, TGT_B);
        train(ADDR_B + 32'd4, TGT_B);
        redirect(ADDR_B);
        repeat (4) @(posedge clk);
        inst_ok_2 <= 1'b0;
        redirect(ADDR_A);
        repeat (4) @(posedge clk);
        inst_ok_2 <= 1'b1;
        idle_gap();
        // mispredict flush in each state.
        for (int s = 0; s < 3; s++) begin
            redirect(ADDR_B);
            repeat (s) @(posedge clk);
            mispredict(RESET_PC + 32'h728 + 32'(s * 16), s[0], TGT_B + 32'h80, s == 1);
            repeat (3) @(posedge clk);
            idle_gap();
        end
        mispredict(RESET_PC + 32'h760, 1'b0, 32'h0, 1'b0);
        repeat (4) @(posedge clk);
        $display("checks failed: %0d, jumps reported: %0d, cycles: %0d",
                 errors, sh_total, cycles);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/mips_isa_pkg.sv
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/branch_predictor.sv
hw/dynamic_fetch.sv
hw/fetch_unit.sv
tests/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_unit \
    -f flist.f \
    -o sim_fetch_unit

./obj_dir/sim_fetch_unit | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: failure reported"
    exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: no pass line in log"
    exit 1
fi

echo "run_sim: passed"
